// ==== dual_issue_defs.svh ====
`ifndef DUAL_ISSUE_DEFS_SVH
`define DUAL_ISSUE_DEFS_SVH

// Data path widths.
`define DI_WORD_W     32
`define DI_REG_W      3
`define DI_IMM_W      16

// Data memory, word addressed from the low result bits.
`define DI_DMEM_DEPTH 16
`define DI_DMEM_AW    4

`endif

// ==== dual_issue_pkg.sv ====
`include "dual_issue_defs.svh"

package dual_issue_pkg;

    typedef logic [`DI_WORD_W-1:0]  word_t;
    typedef logic [`DI_REG_W-1:0]   reg_idx_t;
    typedef logic [`DI_IMM_W-1:0]   imm_t;
    typedef logic [`DI_DMEM_AW-1:0] dmem_addr_t;
    typedef logic [2:0]             fwd_sel_t;

    // Operand sources.
    localparam fwd_sel_t FWD_RF   = 3'd0;
    localparam fwd_sel_t FWD_MEM1 = 3'd1;
    localparam fwd_sel_t FWD_MEM2 = 3'd2;
    localparam fwd_sel_t FWD_WB1  = 3'd3;
    localparam fwd_sel_t FWD_WB2  = 3'd4;

    typedef enum logic [2:0] {
        NOP  = 3'd0,
        ADD  = 3'd1,
        SUB  = 3'd2,
        ADDI = 3'd3,
        LW   = 3'd4,
        SW   = 3'd5
    } op_t;

    typedef struct packed {
        op_t      op;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        imm_t     imm;
    } instr_t;

    // Slot1 is the older instruction.
    typedef struct packed {
        instr_t slot1;
        instr_t slot2;
    } instr_pair_t;

    typedef struct packed {
        logic     valid;
        op_t      op;
        reg_idx_t rd;
        reg_idx_t rs;
        reg_idx_t rt;
        imm_t     imm;
    } lane_ctl_t;

    typedef struct packed {
        logic       rd_en;
        logic       wr_en;
        dmem_addr_t addr;
        word_t      wdata;
    } mem_req_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

    typedef enum logic {
        ISS_PAIR,
        ISS_SECOND
    } iss_state_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_SECOND
    } arb_state_t;

endpackage

// ==== reg_file.sv ====
`timescale 1ns/100ps
`include "dual_issue_defs.svh"

module reg_file import dual_issue_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rd_idx [4],
    output word_t    rd_data [4],
    input  wb_t      wb1,
    input  wb_t      wb2
);

    word_t regs [1 << `DI_REG_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << `DI_REG_W); i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb1.valid && wb1.rd != '0) begin
                regs[wb1.rd] <= wb1.data;
            end
            // Lane 2 is younger, its write lands last.
            if (wb2.valid && wb2.rd != '0) begin
                regs[wb2.rd] <= wb2.data;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (rd_idx[p] == '0) begin
                rd_data[p] = '0;
            end else if (wb2.valid && wb2.rd == rd_idx[p]) begin
                rd_data[p] = wb2.data;
            end else if (wb1.valid && wb1.rd == rd_idx[p]) begin
                rd_data[p] = wb1.data;
            end else begin
                rd_data[p] = regs[rd_idx[p]];
            end
        end
    end

endmodule

// ==== hazard_issue.sv ====
`timescale 1ns/100ps
`include "dual_issue_defs.svh"

module hazard_issue import dual_issue_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        issue,
    input  instr_pair_t pair,
    input  logic        mem_busy,
    input  lane_ctl_t   ex_ctl1,
    input  lane_ctl_t   ex_ctl2,
    output logic        hold,
    output lane_ctl_t   id_ctl1,
    output lane_ctl_t   id_ctl2
);

    iss_state_t state;
    lane_ctl_t  c1, c2, cand1, cand2;
    logic       dep, split, load_use;

    // Unused register fields stay zero, so r0 never looks like a hazard.
    function automatic lane_ctl_t decode(instr_t ins, logic v);
        lane_ctl_t c;
        c = '0;
        if (v) begin
            case (ins.op)
                ADD, SUB: begin
                    c.rd = ins.rd;
                    c.rs = ins.rs;
                    c.rt = ins.rt;
                end
                ADDI, LW: begin
                    c.rd = ins.rd;
                    c.rs = ins.rs;
                end
                SW: begin
                    c.rs = ins.rs;
                    c.rt = ins.rt;
                end
                default: ;
            endcase
            c.valid = (ins.op != NOP);
            c.op    = ins.op;
            c.imm   = ins.imm;
        end
        return c;
    endfunction

    function automatic logic reads(lane_ctl_t c, reg_idx_t r);
        return c.valid && (r != '0) && (c.rs == r || c.rt == r);
    endfunction

    function automatic logic load_hit(lane_ctl_t c, lane_ctl_t ex);
        return ex.valid && (ex.op == LW) && reads(c, ex.rd);
    endfunction

    always_comb begin
        c1  = decode(pair.slot1, issue);
        c2  = decode(pair.slot2, issue);
        dep = c1.valid && (c1.rd != '0) && c2.valid
              && (reads(c2, c1.rd) || c2.rd == c1.rd);
        if (state == ISS_SECOND) begin
            cand1 = c2;
            cand2 = '0;
            split = 1'b0;
        end else begin
            cand1 = c1;
            cand2 = dep ? '0 : c2;
            split = dep;
        end
        load_use = load_hit(cand1, ex_ctl1) || load_hit(cand1, ex_ctl2)
                   || load_hit(cand2, ex_ctl1) || load_hit(cand2, ex_ctl2);
        // Bubble in front of a load consumer.
        id_ctl1 = load_use ? '0 : cand1;
        id_ctl2 = load_use ? '0 : cand2;
        hold    = mem_busy || load_use || split;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ISS_PAIR;
        end else if (!mem_busy && !load_use) begin
            if (state == ISS_SECOND) begin
                state <= ISS_PAIR;
            end else if (split) begin
                state <= ISS_SECOND;
            end
        end
    end

endmodule

// ==== forwarding_unit.sv ====
`timescale 1ns/100ps
`include "dual_issue_defs.svh"

module forwarding_unit import dual_issue_pkg::*; (
    input  lane_ctl_t ex_ctl1,
    input  lane_ctl_t ex_ctl2,
    input  lane_ctl_t mem_ctl1,
    input  lane_ctl_t mem_ctl2,
    input  wb_t       wb1,
    input  wb_t       wb2,
    output fwd_sel_t  sel_a1,
    output fwd_sel_t  sel_b1,
    output fwd_sel_t  sel_a2,
    output fwd_sel_t  sel_b2
);

    // Nearest stage first, lane 2 first within a stage.
    function automatic fwd_sel_t pick(reg_idx_t r, lane_ctl_t m1, lane_ctl_t m2,
                                      wb_t w1, wb_t w2);
        fwd_sel_t s;
        if (r == '0) begin
            s = FWD_RF;
        end else if (m2.valid && m2.op != LW && m2.rd == r) begin
            s = FWD_MEM2;
        end else if (m1.valid && m1.op != LW && m1.rd == r) begin
            s = FWD_MEM1;
        end else if (w2.valid && w2.rd == r) begin
            s = FWD_WB2;
        end else if (w1.valid && w1.rd == r) begin
            s = FWD_WB1;
        end else begin
            s = FWD_RF;
        end
        return s;
    endfunction

    assign sel_a1 = pick(ex_ctl1.rs, mem_ctl1, mem_ctl2, wb1, wb2);
    assign sel_b1 = pick(ex_ctl1.rt, mem_ctl1, mem_ctl2, wb1, wb2);
    assign sel_a2 = pick(ex_ctl2.rs, mem_ctl1, mem_ctl2, wb1, wb2);
    assign sel_b2 = pick(ex_ctl2.rt, mem_ctl1, mem_ctl2, wb1, wb2);

endmodule

// ==== exec_lane.sv ====
`timescale 1ns/100ps
`include "dual_issue_defs.svh"

module exec_lane import dual_issue_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  lane_ctl_t id_ctl,
    input  word_t     id_a,
    input  word_t     id_b,
    input  fwd_sel_t  sel_a,
    input  fwd_sel_t  sel_b,
    input  word_t     mem_res1,
    input  word_t     mem_res2,
    input  wb_t       wb1,
    input  wb_t       wb2,
    input  logic      mem_busy,
    output lane_ctl_t ex_ctl,
    output lane_ctl_t mem_ctl,
    output mem_req_t  mem_req,
    output word_t     alu_res
);

    word_t ex_a, ex_b, fwd_a, fwd_b, imm_ext, alu_out, mem_b;

    function automatic word_t pick_src(fwd_sel_t s, word_t rf, word_t m1, word_t m2,
                                       wb_t w1, wb_t w2);
        word_t v;
        case (s)
            FWD_MEM1: v = m1;
            FWD_MEM2: v = m2;
            FWD_WB1:  v = w1.data;
            FWD_WB2:  v = w2.data;
            default:  v = rf;
        endcase
        return v;
    endfunction

    assign fwd_a   = pick_src(sel_a, ex_a, mem_res1, mem_res2, wb1, wb2);
    assign fwd_b   = pick_src(sel_b, ex_b, mem_res1, mem_res2, wb1, wb2);
    assign imm_ext = {{(`DI_WORD_W - `DI_IMM_W){ex_ctl.imm[`DI_IMM_W-1]}}, ex_ctl.imm};

    always_comb begin
        case (ex_ctl.op)
            ADD:          alu_out = fwd_a + fwd_b;
            SUB:          alu_out = fwd_a - fwd_b;
            ADDI, LW, SW: alu_out = fwd_a + imm_ext;
            default:      alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_ctl  <= '0;
            mem_ctl <= '0;
        end else if (!mem_busy) begin
            ex_ctl  <= id_ctl;
            mem_ctl <= ex_ctl;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_busy) begin
            // WB empties under a stall, keep what it forwarded.
            ex_a <= fwd_a;
            ex_b <= fwd_b;
        end else begin
            ex_a    <= id_a;
            ex_b    <= id_b;
            alu_res <= alu_out;
            mem_b   <= fwd_b;
        end
    end

    always_comb begin
        mem_req.rd_en = mem_ctl.valid && (mem_ctl.op == LW);
        mem_req.wr_en = mem_ctl.valid && (mem_ctl.op == SW);
        mem_req.addr  = alu_res[`DI_DMEM_AW-1:0];
        mem_req.wdata = mem_b;
    end

endmodule

// ==== dmem_arbiter.sv ====
`timescale 1ns/100ps
`include "dual_issue_defs.svh"

module dmem_arbiter import dual_issue_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  mem_req_t req1,
    input  mem_req_t req2,
    input  word_t    res_in1,
    input  word_t    res_in2,
    output word_t    res1,
    output word_t    res2,
    output logic     mem_busy
);

    word_t      mem [`DI_DMEM_DEPTH];
    arb_state_t state;
    mem_req_t   port;
    word_t      rdata, rdata1_q;
    logic       acc1, acc2;

    always_comb begin
        acc1     = req1.rd_en || req1.wr_en;
        acc2     = req2.rd_en || req2.wr_en;
        mem_busy = acc1 && acc2 && (state == ARB_IDLE);
        // Lane 1 owns the port in ARB_IDLE when it needs it.
        port     = (state == ARB_IDLE && acc1) ? req1 : req2;
        rdata    = mem[port.addr];
        if (!req1.rd_en) begin
            res1 = res_in1;
        end else if (state == ARB_SECOND) begin
            res1 = rdata1_q;
        end else begin
            res1 = rdata;
        end
        res2 = req2.rd_en ? rdata : res_in2;
    end

    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            mem[port.addr] <= port.wdata;
        end
        // Lane 1 load data, kept for the second cycle.
        if (mem_busy) begin
            rdata1_q <= rdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
        end else if (mem_busy) begin
            state <= ARB_SECOND;
        end else begin
            state <= ARB_IDLE;
        end
    end

endmodule

// ==== dual_issue.sv ====
`timescale 1ns/100ps
`include "dual_issue_defs.svh"

module dual_issue import dual_issue_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        issue,
    input  instr_pair_t pair,
    output logic        hold,
    output wb_t         out1,
    output wb_t         out2
);

    lane_ctl_t id_ctl1, id_ctl2, ex_ctl1, ex_ctl2, mem_ctl1, mem_ctl2;
    reg_idx_t  rd_idx [4];
    word_t     rd_data [4];
    fwd_sel_t  sel_a1, sel_b1, sel_a2, sel_b2;
    mem_req_t  mem_req1, mem_req2;
    word_t     alu_res1, alu_res2, res1, res2;
    logic      mem_busy;

    function automatic wb_t to_wb(lane_ctl_t c, word_t d);
        wb_t w;
        w.valid = c.valid && (c.rd != '0);
        w.rd    = c.rd;
        w.data  = d;
        return w;
    endfunction

    assign rd_idx = '{id_ctl1.rs, id_ctl1.rt, id_ctl2.rs, id_ctl2.rt};

    reg_file u_reg_file (.clk, .rst_n, .rd_idx, .rd_data, .wb1(out1), .wb2(out2));

    hazard_issue u_hazard_issue (
        .clk, .rst_n, .issue, .pair, .mem_busy,
        .ex_ctl1, .ex_ctl2, .hold, .id_ctl1, .id_ctl2
    );

    forwarding_unit u_forwarding_unit (
        .ex_ctl1, .ex_ctl2, .mem_ctl1, .mem_ctl2, .wb1(out1), .wb2(out2),
        .sel_a1, .sel_b1, .sel_a2, .sel_b2
    );

    exec_lane lane1 (
        .clk, .rst_n, .id_ctl(id_ctl1), .id_a(rd_data[0]), .id_b(rd_data[1]),
        .sel_a(sel_a1), .sel_b(sel_b1), .mem_res1(alu_res1), .mem_res2(alu_res2),
        .wb1(out1), .wb2(out2), .mem_busy, .ex_ctl(ex_ctl1), .mem_ctl(mem_ctl1),
        .mem_req(mem_req1), .alu_res(alu_res1)
    );

    exec_lane lane2 (
        .clk, .rst_n, .id_ctl(id_ctl2), .id_a(rd_data[2]), .id_b(rd_data[3]),
        .sel_a(sel_a2), .sel_b(sel_b2), .mem_res1(alu_res1), .mem_res2(alu_res2),
        .wb1(out1), .wb2(out2), .mem_busy, .ex_ctl(ex_ctl2), .mem_ctl(mem_ctl2),
        .mem_req(mem_req2), .alu_res(alu_res2)
    );

    dmem_arbiter u_dmem_arbiter (
        .clk, .rst_n, .req1(mem_req1), .req2(mem_req2), .res_in1(alu_res1),
        .res_in2(alu_res2), .res1, .res2, .mem_busy
    );

    // MEM/WB registers, empty while memory is serializing.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out1 <= '0;
            out2 <= '0;
        end else if (mem_busy) begin
            out1 <= '0;
            out2 <= '0;
        end else begin
            out1 <= to_wb(mem_ctl1, res1);
            out2 <= to_wb(mem_ctl2, res2);
        end
    end

endmodule

// ==== dual_issue_sva.sv ====
`timescale 1ns/100ps

module dual_issue_sva import dual_issue_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic hold,
    input wb_t  out1,
    input wb_t  out2
);

    int fails_reset = 0;
    int fails_hold  = 0;
    int fails_r0    = 0;
    int hold_run;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_run <= 0;
        end else if (hold) begin
            hold_run <= hold_run + 1;
        end else begin
            hold_run <= 0;
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> (!out1.valid && !out2.valid))
        else begin
            $error("Writeback valid in the first cycle after reset.");
            fails_reset++;
        end

    // Two memory stalls, a load-use bubble and a split can chain to five cycles.
    a_hold_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        hold_run <= 5)
        else begin
            $error("Hold stayed high for more than five cycles.");
            fails_hold++;
        end

    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        (!out1.valid || out1.rd != '0) && (!out2.valid || out2.rd != '0))
        else begin
            $error("Valid writeback targets r0.");
            fails_r0++;
        end

endmodule

bind dual_issue dual_issue_sva u_sva (.clk, .rst_n, .hold, .out1, .out2);

// ==== tb_dual_issue.sv ====
`timescale 1ns/100ps
`include "dual_issue_defs.svh"

module tb_dual_issue import dual_issue_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam op_t RAND_OPS [6] = '{NOP, ADD, SUB, ADDI, LW, SW};

    logic        clk;
    logic        rst_n;
    logic        issue;
    instr_pair_t pair;
    logic        hold;
    wb_t         out1;
    wb_t         out2;

    word_t       model_regs [1 << `DI_REG_W];
    word_t       model_mem [`DI_DMEM_DEPTH];
    wb_t         expected [$];
    string       test_name;
    int          pairs_sent;
    int          cycles;
    logic [31:0] rng_state;

    dual_issue dut (.clk, .rst_n, .issue, .pair, .hold, .out1, .out2);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first failure.");
    endtask

    task automatic check_wb(string port, wb_t exp, wb_t act);
        string msg;
        if (act !== exp) begin
            msg = $sformatf("Error %s: %s expected valid=%0b rd=r%0d data=%h,",
                            test_name, port, exp.valid, exp.rd, exp.data);
            msg = {msg, $sformatf(" actual valid=%0b rd=r%0d data=%h",
                                  act.valid, act.rd, act.data)};
            abort_run(msg);
        end
    endtask

    task automatic check_count(int exp, int act);
        if (act != exp) begin
            abort_run($sformatf("Error %s: pending results expected %0d, actual %0d",
                test_name, exp, act));
        end
    endtask

    task automatic take_result(string port, wb_t act);
        wb_t exp;
        if (expected.size() == 0) begin
            abort_run($sformatf("Unexpected writeback on %s during test %s.", port, test_name));
        end else begin
            exp = expected.pop_front();
            check_wb(port, exp, act);
        end
    endtask

    // Outputs change on the rising edge and are read half a cycle later.
    always @(negedge clk) begin
        if (dut.u_sva.fails_reset + dut.u_sva.fails_hold + dut.u_sva.fails_r0 != 0) begin
            abort_run("The bound assertion checker reported a failure.");
        end
        if (rst_n) begin
            if (out1.valid) begin
                take_result("out1", out1);
            end
            if (out2.valid) begin
                take_result("out2", out2);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * pairs_sent + 100) begin
            abort_run($sformatf("Watchdog timeout in test %s, the core stopped making progress.",
                test_name));
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic instr_t make_instr(op_t op, int rd, int rs, int rt, int imm);
        instr_t i;
        i.op  = op;
        i.rd  = reg_idx_t'(rd);
        i.rs  = reg_idx_t'(rs);
        i.rt  = reg_idx_t'(rt);
        i.imm = imm_t'(imm);
        return i;
    endfunction

    function automatic instr_t random_instr();
        logic [31:0] r;
        r = next_rand();
        return make_instr(RAND_OPS[r[31:16] % 6], r[2:0], r[5:3], r[8:6], int'(r[12:9]) - 8);
    endfunction

    function automatic word_t sign_extend(imm_t imm);
        return {{(`DI_WORD_W - `DI_IMM_W){imm[`DI_IMM_W-1]}}, imm};
    endfunction

    // Reference execution in program order.
    task automatic model_step(instr_t ins);
        word_t      a, b, v;
        dmem_addr_t addr;
        logic       writes;
        wb_t        w;
        a      = model_regs[ins.rs];
        b      = model_regs[ins.rt];
        addr   = dmem_addr_t'(a + sign_extend(ins.imm));
        v      = '0;
        writes = 1'b1;
        case (ins.op)
            ADD:  v = a + b;
            SUB:  v = a - b;
            ADDI: v = a + sign_extend(ins.imm);
            LW:   v = model_mem[addr];
            SW: begin
                model_mem[addr] = b;
                writes = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        if (writes && ins.rd != '0) begin
            model_regs[ins.rd] = v;
            w.valid = 1'b1;
            w.rd    = ins.rd;
            w.data  = v;
            expected.push_back(w);
        end
    endtask

    task automatic send_pair(instr_t s1, instr_t s2);
        logic held;
        model_step(s1);
        model_step(s2);
        pairs_sent++;
        @(negedge clk);
        issue      = 1'b1;
        pair.slot1 = s1;
        pair.slot2 = s2;
        held       = 1'b1;
        while (held) begin
            #(CLK_PERIOD / 4);
            held = hold;
            @(posedge clk);
            if (held) begin
                @(negedge clk);
            end
        end
    endtask

    task automatic drain(int limit);
        int n;
        @(negedge clk);
        issue = 1'b0;
        pair  = '0;
        n     = 0;
        while (expected.size() != 0 && n < limit) begin
            @(negedge clk);
            n++;
        end
        check_count(0, expected.size());
    endtask

    // Every address gets a value, so no load ever reads an unwritten word.
    task automatic init_memory();
        test_name = "memory_init";
        for (int a = 0; a < `DI_DMEM_DEPTH; a++) begin
            send_pair(make_instr(ADDI, 1, 0, 0, 37 * a + 11), make_instr(SW, 0, 0, 1, a));
        end
        drain(100);
    endtask

    task automatic test_independent();
        test_name = "independent_alu";
        send_pair(make_instr(ADDI, 1, 0, 0, 5), make_instr(ADDI, 2, 0, 0, -3));
        send_pair(make_instr(ADDI, 3, 0, 0, 1000), make_instr(ADDI, 4, 0, 0, 7));
        send_pair(make_instr(ADD, 5, 1, 3, 0), make_instr(SUB, 6, 4, 2, 0));
        send_pair(make_instr(ADDI, 0, 1, 0, 9), make_instr(ADD, 7, 0, 4, 0));
        send_pair(make_instr(SUB, 1, 7, 0, 0), make_instr(ADD, 2, 0, 0, 0));
        drain(60);
    endtask

    task automatic test_split();
        test_name = "split_pairs";
        send_pair(make_instr(ADDI, 1, 0, 0, 10), make_instr(ADD, 2, 1, 1, 0));
        send_pair(make_instr(ADD, 3, 2, 1, 0), make_instr(SUB, 3, 3, 2, 0));
        send_pair(make_instr(ADDI, 4, 0, 0, 1), make_instr(ADDI, 4, 0, 0, 2));
        send_pair(make_instr(ADDI, 5, 4, 0, -6), make_instr(SW, 0, 0, 5, 6));
        drain(60);
    endtask

    task automatic test_forwarding();
        test_name = "forwarding";
        send_pair(make_instr(ADDI, 1, 0, 0, 1), make_instr(ADDI, 2, 0, 0, 2));
        send_pair(make_instr(ADDI, 3, 0, 0, 3), make_instr(ADDI, 4, 0, 0, 4));
        send_pair(make_instr(ADD, 5, 1, 4, 0), make_instr(SUB, 6, 3, 2, 0));
        send_pair(make_instr(ADD, 7, 6, 5, 0), make_instr(ADD, 1, 5, 6, 0));
        send_pair(make_instr(ADDI, 2, 0, 0, 50), make_instr(ADDI, 2, 0, 0, 60));
        send_pair(make_instr(ADD, 3, 2, 7, 0), make_instr(SUB, 4, 2, 1, 0));
        drain(60);
    endtask

    task automatic test_load_use();
        test_name = "load_use";
        send_pair(make_instr(LW, 1, 0, 0, 3), make_instr(NOP, 0, 0, 0, 0));
        send_pair(make_instr(ADD, 2, 1, 1, 0), make_instr(ADDI, 3, 1, 0, 1));
        send_pair(make_instr(NOP, 0, 0, 0, 0), make_instr(LW, 4, 0, 0, 7));
        send_pair(make_instr(SUB, 5, 4, 2, 0), make_instr(NOP, 0, 0, 0, 0));
        send_pair(make_instr(LW, 6, 0, 0, 2), make_instr(ADD, 7, 6, 6, 0));
        send_pair(make_instr(ADDI, 1, 0, 0, 77), make_instr(NOP, 0, 0, 0, 0));
        send_pair(make_instr(SW, 0, 0, 1, 5), make_instr(NOP, 0, 0, 0, 0));
        send_pair(make_instr(LW, 2, 0, 0, 5), make_instr(NOP, 0, 0, 0, 0));
        send_pair(make_instr(ADD, 3, 2, 0, 0), make_instr(NOP, 0, 0, 0, 0));
        drain(80);
    endtask

    task automatic test_mem_conflict();
        test_name = "memory_conflict";
        send_pair(make_instr(ADDI, 4, 0, 0, -21), make_instr(ADDI, 5, 0, 0, 9));
        send_pair(make_instr(SW, 0, 5, 4, 0), make_instr(LW, 6, 5, 0, 0));
        send_pair(make_instr(LW, 1, 0, 0, 2), make_instr(LW, 2, 0, 0, 3));
        send_pair(make_instr(LW, 3, 0, 0, 4), make_instr(SW, 0, 0, 6, 4));
        send_pair(make_instr(ADD, 5, 1, 2, 0), make_instr(LW, 7, 0, 0, 4));
        drain(80);
    endtask

    task automatic test_random();
        instr_t s1, s2;
        test_name = "random";
        for (int n = 0; n < 200; n++) begin
            s1 = random_instr();
            s2 = random_instr();
            send_pair(s1, s2);
        end
        drain(200);
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        issue      = 1'b0;
        pair       = '0;
        pairs_sent = 0;
        cycles     = 0;
        rng_state  = 32'hb60808db;
        test_name  = "reset";
        for (int i = 0; i < (1 << `DI_REG_W); i++) begin
            model_regs[i] = '0;
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        init_memory();
        test_independent();
        test_split();
        test_forwarding();
        test_load_use();
        test_mem_conflict();
        test_random();
        if (dut.u_sva.fails_reset + dut.u_sva.fails_hold + dut.u_sva.fails_r0 == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            abort_run("The bound assertion checker reported failures.");
        end
    end

endmodule

// ==== verilog.f ====
+incdir+.
dual_issue_pkg.sv
reg_file.sv
hazard_issue.sv
forwarding_unit.sv
exec_lane.sv
dmem_arbiter.sv
dual_issue.sv
dual_issue_sva.sv
tb_dual_issue.sv
